// File: hw/cfg_port_pkg.sv
package cfg_port_pkg;

	// ------------------------------------------------------------------
	// bus geometry
	// ------------------------------------------------------------------

	// address bus, only bits 5:4 reach the memory
	localparam int addr_width = 16;

	// one beat is one full memory row
	localparam int data_width = 128;
	localparam int data_bytes = data_width / 8;

	// first address bit above the byte offset
	localparam int addr_lsb = $clog2(data_bytes);

	// ------------------------------------------------------------------
	// configuration memory
	// ------------------------------------------------------------------

	localparam int mem_bytes = 64;
	localparam int mem_rows = mem_bytes / data_bytes;
	localparam int row_bits = $clog2(mem_rows);

	// ------------------------------------------------------------------
	// burst and response encodings
	// ------------------------------------------------------------------

	localparam int len_width = 8;
	localparam int burst_width = 2;
	localparam int resp_width = 2;

	localparam logic [burst_width-1:0] burst_fixed = 2'd0;
	localparam logic [burst_width-1:0] burst_incr = 2'd1;

	// no error responses, every beat answers OKAY
	localparam logic [resp_width-1:0] resp_okay = 2'd0;

	// one row seen either as a data word or as its byte lanes
	// byte 0 sits in bits 7:0, same as wstrb bit 0
	typedef union packed {
		logic [data_width-1:0] word;
		logic [data_bytes-1:0][7:0] bytes;
	} cfg_word_t;

endpackage

// File: hw/cfg_write_channel.sv
module cfg_write_channel (
	input logic S_AXI_ACLK,
	input logic S_AXI_ARESETN,
	// write address
	input logic [cfg_port_pkg::addr_width-1:0] awaddr,
	input logic [cfg_port_pkg::len_width-1:0] awlen,
	input logic [cfg_port_pkg::burst_width-1:0] awburst,
	input logic awvalid,
	output logic awready,
	// write data, payload goes straight to the memory
	input logic wlast,
	input logic wvalid,
	output logic wready,
	// write response
	output logic [cfg_port_pkg::resp_width-1:0] bresp,
	output logic bvalid,
	input logic bready,
	// exclusion and memory side
	input logic rd_busy,
	output logic wr_busy,
	output logic [cfg_port_pkg::row_bits-1:0] wr_row,
	output logic wr_en
);

	import cfg_port_pkg::*;

	// latched burst fields
	logic [len_width-1:0] len;
	logic [burst_width-1:0] burst;
	logic [len_width-1:0] beat_cnt;

	logic aw_start;
	logic beat_ok;

	// a new write may only begin while the read engine is idle
	// on a tie with arvalid the write takes the port
	assign aw_start = !wr_busy && awvalid && !rd_busy;

	// data beat handshake
	assign beat_ok = wready && wvalid;

	// beats past the burst length are dropped
	assign wr_en = beat_ok && (beat_cnt <= len);

	assign bresp = resp_okay;

	// ------------------------------------------------------------------
	// handshake control
	// ------------------------------------------------------------------

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			awready <= 1'b0;
			wready <= 1'b0;
			bvalid <= 1'b0;
			wr_busy <= 1'b0;
		end
		else
		begin
			// awready is a single cycle pulse, busy blocks a repeat
			awready <= aw_start;

			// busy spans address accept up to the B handshake
			if (aw_start)
				wr_busy <= 1'b1;
			else if (bvalid && bready)
				wr_busy <= 1'b0;

			// wready opens one cycle after wvalid is seen
			// and closes on the last beat
			if (beat_ok && wlast)
				wready <= 1'b0;
			else if (wr_busy && !wready && wvalid && !bvalid)
				wready <= 1'b1;

			// response follows the last beat, held until bready
			if (beat_ok && wlast)
				bvalid <= 1'b1;
			else if (bvalid && bready)
				bvalid <= 1'b0;
		end
	end

	// ------------------------------------------------------------------
	// burst address and beat count
	// ------------------------------------------------------------------

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (aw_start)
		begin
			// high address bits alias onto the same rows
			wr_row <= awaddr[addr_lsb +: row_bits];
			len <= awlen;
			burst <= awburst;
			beat_cnt <= '0;
		end
		else if (beat_ok)
		begin
			beat_cnt <= beat_cnt + 1'b1;
			case (burst)
				burst_fixed:
					wr_row <= wr_row;
				burst_incr:
					wr_row <= wr_row + 1'b1;
				// reserved and wrap encodings step like INCR
				default:
					wr_row <= wr_row + 1'b1;
			endcase
		end
	end

	// write data is never taken outside a transaction
	wready_in_busy: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		wready |-> wr_busy);

	// response stays up until the master takes it
	bvalid_held: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		bvalid && !bready |=> bvalid);

endmodule

// File: hw/cfg_read_channel.sv
module cfg_read_channel (
	input logic S_AXI_ACLK,
	input logic S_AXI_ARESETN,
	// read address
	input logic [cfg_port_pkg::addr_width-1:0] araddr,
	input logic [cfg_port_pkg::len_width-1:0] arlen,
	input logic [cfg_port_pkg::burst_width-1:0] arburst,
	input logic arvalid,
	output logic arready,
	// read data
	output logic [cfg_port_pkg::data_width-1:0] rdata,
	output logic [cfg_port_pkg::resp_width-1:0] rresp,
	output logic rlast,
	output logic rvalid,
	input logic rready,
	// exclusion, awvalid gives the write side priority
	input logic awvalid,
	input logic wr_busy,
	// memory side
	input cfg_port_pkg::cfg_word_t rd_word,
	output logic rd_busy,
	output logic [cfg_port_pkg::row_bits-1:0] rd_row
);

	import cfg_port_pkg::*;

	// latched burst fields
	logic [len_width-1:0] len;
	logic [burst_width-1:0] burst;
	logic [len_width-1:0] beat_cnt;

	logic ar_start;
	logic r_hs;

	// start only with the write side idle and no write address pending
	assign ar_start = !rd_busy && arvalid && !wr_busy && !awvalid;

	// read data handshake
	assign r_hs = rvalid && rready;

	// bus reads zero between beats
	assign rdata = rvalid ? rd_word.word : '0;
	assign rresp = resp_okay;

	// ------------------------------------------------------------------
	// handshake control
	// ------------------------------------------------------------------

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			arready <= 1'b0;
			rvalid <= 1'b0;
			rlast <= 1'b0;
			rd_busy <= 1'b0;
		end
		else
		begin
			// single cycle accept pulse
			arready <= ar_start;

			// busy ends on the handshake of the final beat
			if (ar_start)
				rd_busy <= 1'b1;
			else if (r_hs && rlast)
				rd_busy <= 1'b0;

			// each beat waits one cycle for the registered row,
			// then holds until rready
			if (r_hs)
			begin
				rvalid <= 1'b0;
				rlast <= 1'b0;
			end
			else if (rd_busy && !rvalid)
			begin
				rvalid <= 1'b1;
				rlast <= (beat_cnt == len);
			end
		end
	end

	// ------------------------------------------------------------------
	// burst address and beat count
	// ------------------------------------------------------------------

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (ar_start)
		begin
			// only bits 5:4 pick the row
			rd_row <= araddr[addr_lsb +: row_bits];
			len <= arlen;
			burst <= arburst;
			beat_cnt <= '0;
		end
		else if (r_hs)
		begin
			beat_cnt <= beat_cnt + 1'b1;
			// next row is ready before rvalid rises again
			case (burst)
				burst_fixed:
					rd_row <= rd_row;
				burst_incr:
					rd_row <= rd_row + 1'b1;
				// reserved encoding treated as INCR
				default:
					rd_row <= rd_row + 1'b1;
			endcase
		end
	end

	// a beat is only offered inside a read transaction
	rvalid_in_busy: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		rvalid |-> rd_busy);

endmodule

// File: hw/cfg_memory.sv
module cfg_memory (
	input logic S_AXI_ACLK,
	input logic S_AXI_ARESETN,
	// write port from the write engine and the W channel
	input logic wr_en,
	input logic [cfg_port_pkg::row_bits-1:0] wr_row,
	input logic [cfg_port_pkg::data_width-1:0] wdata,
	input logic [cfg_port_pkg::data_bytes-1:0] wstrb,
	// read port from the read engine
	input logic rd_busy,
	input logic [cfg_port_pkg::row_bits-1:0] rd_row,
	output cfg_port_pkg::cfg_word_t rd_word,
	// every row, flat, for the configured logic
	output logic [cfg_port_pkg::mem_rows*cfg_port_pkg::data_width-1:0] memory_out
);

	import cfg_port_pkg::*;

	// configuration rows
	cfg_word_t rows [mem_rows];

	// incoming beat split into byte lanes
	cfg_word_t wr_word;

	assign wr_word.word = wdata;

	// ------------------------------------------------------------------
	// byte strobed write
	// ------------------------------------------------------------------

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			// configuration comes up all zero
			for (int r = 0; r < mem_rows; r++)
				rows[r] <= '0;
		end
		else if (wr_en)
		begin
			// only lanes with their strobe set are touched
			for (int b = 0; b < data_bytes; b++)
			begin
				if (wstrb[b])
					rows[wr_row].bytes[b] <= wr_word.bytes[b];
			end
		end
	end

	// ------------------------------------------------------------------
	// registered read port
	// ------------------------------------------------------------------

	// tracks rd_row while a read runs, the row is stable during a beat
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (rd_busy)
			rd_word <= rows[rd_row];
	end

	// row 0 in the low bits
	always_comb
	begin
		for (int r = 0; r < mem_rows; r++)
			memory_out[r*data_width +: data_width] = rows[r].word;
	end

	// the two engines never own the memory at the same time
	no_rw_overlap: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		!(wr_en && rd_busy));

endmodule

// File: hw/cfg_port.sv
module cfg_port (
	input logic S_AXI_ACLK,
	input logic S_AXI_ARESETN,
	// write address channel
	input logic [cfg_port_pkg::addr_width-1:0] awaddr,
	input logic [cfg_port_pkg::len_width-1:0] awlen,
	input logic [cfg_port_pkg::burst_width-1:0] awburst,
	input logic awvalid,
	output logic awready,
	// write data channel
	input logic [cfg_port_pkg::data_width-1:0] wdata,
	input logic [cfg_port_pkg::data_bytes-1:0] wstrb,
	input logic wlast,
	input logic wvalid,
	output logic wready,
	// write response channel
	output logic [cfg_port_pkg::resp_width-1:0] bresp,
	output logic bvalid,
	input logic bready,
	// read address channel
	input logic [cfg_port_pkg::addr_width-1:0] araddr,
	input logic [cfg_port_pkg::len_width-1:0] arlen,
	input logic [cfg_port_pkg::burst_width-1:0] arburst,
	input logic arvalid,
	output logic arready,
	// read data channel
	output logic [cfg_port_pkg::data_width-1:0] rdata,
	output logic [cfg_port_pkg::resp_width-1:0] rresp,
	output logic rlast,
	output logic rvalid,
	input logic rready,
	// configuration contents
	output logic [cfg_port_pkg::mem_rows*cfg_port_pkg::data_width-1:0] memory_out
);

	import cfg_port_pkg::*;

	// ------------------------------------------------------------------
	// engine to memory wiring
	// ------------------------------------------------------------------

	// write engine owns the port while wr_busy is high
	logic wr_busy;
	logic [row_bits-1:0] wr_row;
	logic wr_en;

	// read engine owns the port while rd_busy is high
	logic rd_busy;
	logic [row_bits-1:0] rd_row;
	cfg_word_t rd_word;

	// AW, W and B channels
	// all port and wire names match, so connect by name
	cfg_write_channel cfg_write_channel_i (
		.*
	);

	// AR and R channels, also sees awvalid for write priority
	cfg_read_channel cfg_read_channel_i (
		.*
	);

	// row store, takes wdata and wstrb straight from the W channel
	cfg_memory cfg_memory_i (
		.S_AXI_ACLK(S_AXI_ACLK),
		.S_AXI_ARESETN(S_AXI_ARESETN),
		.wr_en(wr_en),
		.wr_row(wr_row),
		.wdata(wdata),
		.wstrb(wstrb),
		.rd_busy(rd_busy),
		.rd_row(rd_row),
		.rd_word(rd_word),
		.memory_out(memory_out)
	);

endmodule

// File: bench/cfg_port_checks.svh
`ifndef cfg_port_checks_svh
`define cfg_port_checks_svh

	// ------------------------------------------------------------------
	// counters and compare tasks
	// ------------------------------------------------------------------

	int errors = 0;
	int checks = 0;

	// one 128 bit row against its expected value
	task automatic check_word(input string name, input cfg_word_t got, input cfg_word_t exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("** Error: %s got %h expected %h", name, got.word, exp.word);
		end
	endtask

	// this port only ever answers OKAY
	task automatic check_resp(input string name, input logic [resp_width-1:0] got);
		checks++;
		if (got !== resp_okay)
		begin
			errors++;
			$display("** Error: %s got %h expected %h", name, got, resp_okay);
		end
	endtask

	// last flag against the beat position in the burst
	task automatic check_last(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("** Error: %s got %h expected %h", name, got, exp);
		end
	endtask

	// handshake never arrived
	task automatic report_timeout(input string what);
		errors++;
		$display("timed out after %0d cycles waiting for %s", timeout_cycles, what);
	endtask

`endif

// File: bench/cfg_port_tb.sv
module cfg_port_tb;

	import cfg_port_pkg::*;

	// longest wait for any single handshake, in cycles
	localparam int timeout_cycles = 1000;

	logic S_AXI_ACLK;
	logic S_AXI_ARESETN;
	logic [addr_width-1:0] awaddr, araddr;
	logic [len_width-1:0] awlen, arlen;
	logic [burst_width-1:0] awburst, arburst;
	logic awvalid, awready, wlast, wvalid, wready, bvalid, bready;
	logic arvalid, arready, rlast, rvalid, rready;
	logic [data_width-1:0] wdata, rdata;
	logic [data_bytes-1:0] wstrb;
	logic [resp_width-1:0] bresp, rresp;
	logic [mem_rows*data_width-1:0] memory_out;

	// beats of the current operation, as read from the file
	logic [data_bytes-1:0] strb_a [256];
	cfg_word_t data_a [256];
	cfg_word_t exp_a [256];

	logic [31:0] rng = 32'd79;
	time ar_time = 0;
	time b_time = 0;
	int fd;
	int r;
	int test_num = 0;

	`include "cfg_port_checks.svh"

	cfg_port cfg_port_i (.*);

	initial
	begin
		S_AXI_ACLK = 1'b0;
		forever #5 S_AXI_ACLK = ~S_AXI_ACLK;
	end

	// last time arready was seen, for the collision order
	always @(negedge S_AXI_ACLK)
		if (arready)
			ar_time = $time;

	// ------------------------------------------------------------------
	// random back-pressure
	// ------------------------------------------------------------------

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// ready drops about one cycle in four
	function automatic logic random_ready();
		rng = xorshift32(rng);
		return rng[1:0] != 2'b00;
	endfunction

	// ------------------------------------------------------------------
	// file readers, called on a falling edge
	// ------------------------------------------------------------------

	task automatic load_write();
		logic [data_bytes-1:0] s;
		logic [data_width-1:0] d;
		r = $fscanf(fd, "%h %h %h", awaddr, awlen, awburst);
		for (int i = 0; i <= int'(awlen); i++)
		begin
			r = $fscanf(fd, "%h %h", s, d);
			strb_a[i] = s;
			data_a[i].word = d;
		end
	endtask

	task automatic load_read();
		logic [data_width-1:0] d;
		r = $fscanf(fd, "%h %h %h", araddr, arlen, arburst);
		for (int i = 0; i <= int'(arlen); i++)
		begin
			r = $fscanf(fd, "%h", d);
			exp_a[i].word = d;
		end
	endtask

	// ------------------------------------------------------------------
	// bus driver
	// ------------------------------------------------------------------

	// address, then beats, then response, ends on a falling edge
	task automatic run_write();
		int n;
		awvalid = 1'b1;
		n = 0;
		while (!awready && n < timeout_cycles)
		begin
			@(negedge S_AXI_ACLK);
			n++;
		end
		if (!awready)
			report_timeout("awready");
		@(negedge S_AXI_ACLK);
		awvalid = 1'b0;
		for (int i = 0; i <= int'(awlen); i++)
		begin
			wdata = data_a[i].word;
			wstrb = strb_a[i];
			wlast = (i == int'(awlen));
			wvalid = 1'b1;
			n = 0;
			while (!wready && n < timeout_cycles)
			begin
				@(negedge S_AXI_ACLK);
				n++;
			end
			if (!wready)
				report_timeout("wready");
			@(negedge S_AXI_ACLK);
		end
		wvalid = 1'b0;
		wlast = 1'b0;
		n = 0;
		bready = random_ready();
		while (!(bvalid && bready) && n < timeout_cycles)
		begin
			@(negedge S_AXI_ACLK);
			n++;
			bready = random_ready();
		end
		if (!bvalid)
			report_timeout("bvalid");
		check_resp("bresp", bresp);
		@(negedge S_AXI_ACLK);
		bready = 1'b0;
		b_time = $time;
	endtask

	// every beat checked at its handshake, bus zero in between
	task automatic run_read();
		int n;
		arvalid = 1'b1;
		n = 0;
		while (!arready && n < timeout_cycles)
		begin
			@(negedge S_AXI_ACLK);
			n++;
		end
		if (!arready)
			report_timeout("arready");
		@(negedge S_AXI_ACLK);
		arvalid = 1'b0;
		for (int i = 0; i <= int'(arlen); i++)
		begin
			n = 0;
			rready = random_ready();
			while (!(rvalid && rready) && n < timeout_cycles)
			begin
				if (!rvalid)
					check_word("rdata", rdata, '0);
				@(negedge S_AXI_ACLK);
				n++;
				rready = random_ready();
			end
			if (!rvalid)
				report_timeout("rvalid");
			check_word("rdata", rdata, exp_a[i]);
			check_resp("rresp", rresp);
			check_last("rlast", rlast, i == int'(arlen));
			@(negedge S_AXI_ACLK);
		end
		rready = 1'b0;
	endtask

	task automatic memory_op();
		logic [data_width-1:0] d;
		for (int row = 0; row < mem_rows; row++)
		begin
			r = $fscanf(fd, "%h", d);
			check_word($sformatf("memory_out row %0d", row),
				memory_out[row*data_width +: data_width], d);
		end
	endtask

	// both address channels go valid on the same edge, write first
	task automatic collision_op();
		load_write();
		load_read();
		arvalid = 1'b1;
		run_write();
		run_read();
		if (ar_time <= b_time)
		begin
			errors++;
			$display("arready rose before the write response completed");
		end
	endtask

	// ------------------------------------------------------------------
	// main sequence
	// ------------------------------------------------------------------

	initial
	begin
		logic [7:0] op;
		logic [8*128-1:0] text_line;
		int err_before;
		S_AXI_ARESETN = 1'b0;
		awaddr = '0;
		awlen = '0;
		awburst = '0;
		awvalid = 1'b0;
		wdata = '0;
		wstrb = '0;
		wlast = 1'b0;
		wvalid = 1'b0;
		bready = 1'b0;
		araddr = '0;
		arlen = '0;
		arburst = '0;
		arvalid = 1'b0;
		rready = 1'b0;
		repeat (8) @(posedge S_AXI_ACLK);
		@(negedge S_AXI_ACLK);
		S_AXI_ARESETN = 1'b1;
		@(negedge S_AXI_ACLK);
		fd = $fopen("bench/cfg_port_stimulus.txt", "r");
		if (fd == 0)
		begin
			errors++;
			$display("could not open the stimulus file");
		end
		while (fd != 0 && $fscanf(fd, "%s", op) == 1)
		begin
			if (op == "#")
				r = $fgets(text_line, fd);
			else
			begin
				test_num++;
				err_before = errors;
				case (op)
					"W":
						begin
							load_write();
							run_write();
						end
					"R":
						begin
							load_read();
							run_read();
						end
					"M":
						memory_op();
					"B":
						collision_op();
					default:
						begin
							errors++;
							$display("unknown operation %s in the stimulus file", op);
						end
				endcase
				$display("test %0d %s %s", test_num, op,
					(errors == err_before) ? "passed" : "failed");
			end
		end
		$display("tests %0d, checks %0d, errors %0d", test_num, checks, errors);
		if (errors == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

// File: compile.f
+incdir+bench
hw/cfg_port_pkg.sv
hw/cfg_write_channel.sv
hw/cfg_read_channel.sv
hw/cfg_memory.sv
hw/cfg_port.sv
bench/cfg_port_tb.sv

// File: Makefile
# tools and paths, each one can be set on the command line
VERILATOR ?= verilator
TOP ?= cfg_port_tb
FILELIST ?= compile.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -j 0
PASS_MSG ?= Finished with no errors

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

# the run passes only when the pass line shows up in the output
test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// File: bench/cfg_port_stimulus.txt
# W: addr len burst, then strobe and data per beat
# R: addr len burst, then expected data per beat
# M: expected memory_out rows 0 to 3, B: a W and an R started together
M 0 0 0 0
R 0000 03 1 0 0 0 0
W 0000 03 1
  ffff 00112233445566778899aabbccddeeff ffff 0f1e2d3c4b5a69788796a5b4c3d2e1f0
  ffff deadbeefcafef00d0123456789abcdef ffff 13579bdf2468ace0fedcba9876543210
R 0000 03 1
  00112233445566778899aabbccddeeff 0f1e2d3c4b5a69788796a5b4c3d2e1f0
  deadbeefcafef00d0123456789abcdef 13579bdf2468ace0fedcba9876543210
W 0010 01 1
  8001 11111111111111111111111111111111 0f00 55555555555555555555555555555555
R 0010 01 1
  111e2d3c4b5a69788796a5b4c3d2e111 deadbeef555555550123456789abcdef
M 00112233445566778899aabbccddeeff 111e2d3c4b5a69788796a5b4c3d2e111
  deadbeef555555550123456789abcdef 13579bdf2468ace0fedcba9876543210
W 0030 02 0
  ffff aaaaaaaaaaaaaaaaaaaaaaaaaaaaaaaa ffff bbbbbbbbbbbbbbbbbbbbbbbbbbbbbbbb
  ffff cccccccccccccccccccccccccccccccc
R 0030 01 0
  cccccccccccccccccccccccccccccccc cccccccccccccccccccccccccccccccc
R 0020 01 3
  deadbeef555555550123456789abcdef cccccccccccccccccccccccccccccccc
B ab20 00 1 ffff a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5
  0020 00 1 a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5
M 00112233445566778899aabbccddeeff 111e2d3c4b5a69788796a5b4c3d2e111
  a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5 cccccccccccccccccccccccccccccccc
